/* project.f */
src/snd_pkg.sv
src/snd_regs.sv
src/snd_lfsr.sv
src/snd_lfo.sv
src/snd_vco.sv
src/snd_noise.sv
src/snd_core.sv
src/snd_top.sv
tests/snd_tb.sv

/* Bender.yml */
package:
  name: snd

sources:
  - src/snd_pkg.sv
  - src/snd_regs.sv
  - src/snd_lfsr.sv
  - src/snd_lfo.sv
  - src/snd_vco.sv
  - src/snd_noise.sv
  - src/snd_core.sv
  - src/snd_top.sv
  - target: test
    files:
      - tests/snd_tb.sv

/* tests/snd_tb.sv */
// Directed testbench for the sound chip
// Wishbone read and write tasks, speaker half-period measurement,
// register, mixer, VCO, LFO, noise and modulation tests

`timescale 1ns/1ps
`default_nettype none

module snd_tb;

	logic        clk;
	logic        rst;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [1:0]  wb_adr;
	logic [15:0] wb_dat_w;
	logic [15:0] wb_dat_r;
	logic        wb_ack;
	logic        spkr;
	int          seed = 38816;

	snd_top snd_top_i (
		.clk      (clk),
		.rst      (rst),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.spkr     (spkr)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;	// 100 ns period
	end

	task automatic check_eq(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s expected %0d actual %0d", name, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "Value mismatch in %s", name);
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("Timed out waiting for %s", what);
		$display("STATUS: FAIL");
		$fatal(1, "Timeout on %s", what);
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
	endtask

	task automatic wb_write(input logic [1:0] adr, input logic [15:0] data);
		int waited;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = adr;
		wb_dat_w = data;
		waited   = 0;
		do begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > 16) timeout_fail("write ack");
		end while (!wb_ack);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_read(input logic [1:0] adr, output logic [15:0] data);
		int waited;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = adr;
		waited = 0;
		do begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > 16) timeout_fail("read ack");
		end while (!wb_ack);
		data   = wb_dat_r;	// Valid together with ack
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	// Clocks from now until spkr next changes
	task automatic measure_half(output int clocks, input int limit);
		logic prev;
		prev   = spkr;
		clocks = 0;
		do begin
			@(posedge clk);
			#1;
			clocks++;
			if (clocks > limit) timeout_fail("a speaker edge");
		end while (spkr === prev);
	endtask

	task automatic test_regs();
		logic [15:0] masks [4];
		logic [15:0] values [4];
		logic [15:0] data;
		masks = '{16'h03ff, 16'h0fff, 16'h0fff, 16'h00ff};	// Field widths 10, 12, 12, 8
		check_eq("reset spkr", 0, spkr);
		check_eq("reset ack", 0, wb_ack);
		for (int a = 0; a < 4; a++) begin
			wb_read(a[1:0], data);
			check_eq("reset readback", 0, data);
		end
		for (int a = 0; a < 4; a++) begin
			values[a] = $random(seed);
			wb_write(a[1:0], values[a]);
		end
		for (int a = 0; a < 4; a++) begin
			wb_read(a[1:0], data);
			check_eq("random readback", values[a] & masks[a], data);
		end
	endtask

	task automatic test_mixer_off();
		int waited;
		apply_reset();
		wb_write(2'd3, 16'h0000);
		waited = 0;
		while (spkr !== 1'b1) begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > 32) timeout_fail("spkr high with all sources disabled");
		end
		repeat (1000) begin
			@(posedge clk);
			#1;
			check_eq("mixer off spkr", 1, spkr);
		end
	endtask

	task automatic test_vco();
		int freqs [4];
		int len;
		freqs = '{0, 3, 10, 37};
		apply_reset();
		wb_write(2'd3, 16'h0020);	// VCO only, no modulation
		foreach (freqs[i]) begin
			wb_write(2'd2, freqs[i][15:0]);
			measure_half(len, 5000);	// Old load may still run out
			measure_half(len, 5000);
			repeat (3) begin
				measure_half(len, 5000);
				check_eq("vco half-period", (freqs[i] + 1) * 16, len);
			end
		end
	endtask

	task automatic test_lfo();
		int len;
		apply_reset();
		wb_write(2'd0, 16'd1);
		wb_write(2'd3, 16'h0080);	// LFO only
		measure_half(len, 10000);
		measure_half(len, 10000);
		repeat (3) begin
			measure_half(len, 10000);
			check_eq("lfo half-period", 257 * 16, len);
		end
	endtask

	task automatic test_noise();
		int len;
		apply_reset();
		wb_write(2'd1, 16'd5);
		wb_write(2'd3, 16'h0040);	// Noise only
		measure_half(len, 20000);	// First edge may come from the mixer change
		measure_half(len, 20000);
		repeat (40) begin
			measure_half(len, 20000);
			check_eq("noise interval multiple of 96", 0, len % 96);
		end
	endtask

	task automatic test_vco_mod();
		int len;
		int first;
		int lo;
		int hi;
		logic distinct;
		lo = (4 + 1) * 16;
		hi = (4 + 1 + 1023) * 16;
		apply_reset();
		wb_write(2'd0, 16'd4);
		wb_write(2'd2, 16'd4);
		wb_write(2'd3, 16'h0029);	// VCO only, vco_select, shift 2
		measure_half(len, 20000);
		measure_half(len, 20000);
		distinct = 1'b0;
		first = -1;
		repeat (60) begin
			measure_half(len, 20000);
			check_eq("vco_mod half-period in range", 1, (len >= lo) && (len <= hi));
			if (first < 0) first = len;
			else if (len != first) distinct = 1'b1;
		end
		check_eq("vco_mod distinct half-periods", 1, distinct);
	endtask

	initial begin
		rst      = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = 2'd0;
		wb_dat_w = 16'h0000;
		apply_reset();
		test_regs();
		test_mixer_off();
		test_vco();
		test_lfo();
		test_noise();
		test_vco_mod();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* src/snd_top.sv */
// Sound chip top level
// Connects the Wishbone register bank to the sound core

`timescale 1ns/1ps
`default_nettype none

module snd_top
	import snd_pkg::*;
#(
	parameter int                PRESCALE_LOG2 = 4,
	parameter logic [LFSR_W-1:0] TAPS          = LFSR_TAPS_DEFAULT
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 wb_cyc,
	input  logic                 wb_stb,
	input  logic                 wb_we,
	input  logic [WB_ADR_W-1:0]  wb_adr,
	input  logic [WB_DATA_W-1:0] wb_dat_w,
	output logic [WB_DATA_W-1:0] wb_dat_r,
	output logic                 wb_ack,
	output logic                 spkr
);

	logic [LFO_FREQ_W-1:0] lfo_freq;
	logic [OSC_FREQ_W-1:0] noise_freq;
	logic [OSC_FREQ_W-1:0] vco_freq;
	logic                  vco_select;
	logic                  noise_select;
	logic [SHIFT_W-1:0]    lfo_shift;
	logic [MIX_W-1:0]      mixer;

	snd_regs snd_regs_i (
		.clk          (clk),
		.rst          (rst),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_dat_w     (wb_dat_w),
		.wb_dat_r     (wb_dat_r),
		.wb_ack       (wb_ack),
		.lfo_freq     (lfo_freq),
		.noise_freq   (noise_freq),
		.vco_freq     (vco_freq),
		.vco_select   (vco_select),
		.noise_select (noise_select),
		.lfo_shift    (lfo_shift),
		.mixer        (mixer)
	);

	snd_core #(
		.PRESCALE_LOG2 (PRESCALE_LOG2),
		.TAPS          (TAPS)
	) snd_core_i (
		.clk          (clk),
		.rst          (rst),
		.lfo_freq     (lfo_freq),
		.noise_freq   (noise_freq),
		.vco_freq     (vco_freq),
		.vco_select   (vco_select),
		.noise_select (noise_select),
		.lfo_shift    (lfo_shift),
		.mixer        (mixer),
		.spkr         (spkr)
	);

endmodule

`default_nettype wire

/* src/snd_core.sv */
// Sound core
// Clock prescaler, LFO, VCO and noise oscillators,
// and the registered AND-style speaker mixer

`timescale 1ns/1ps
`default_nettype none

module snd_core
	import snd_pkg::*;
#(
	parameter int                PRESCALE_LOG2 = 4,
	parameter logic [LFSR_W-1:0] TAPS          = LFSR_TAPS_DEFAULT
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [LFO_FREQ_W-1:0] lfo_freq,
	input  logic [OSC_FREQ_W-1:0] noise_freq,
	input  logic [OSC_FREQ_W-1:0] vco_freq,
	input  logic                  vco_select,
	input  logic                  noise_select,
	input  logic [SHIFT_W-1:0]    lfo_shift,
	input  logic [MIX_W-1:0]      mixer,
	output logic                  spkr
);

	logic [PRESCALE_LOG2-1:0] prescale;
	logic                     tick;	// One clock every 2^PRESCALE_LOG2
	logic                     lfo_state;
	logic                     noise_state;
	logic                     vco_state;
	logic [OSC_FREQ_W-1:0]    vco_delta;
	logic [MIX_W-1:0]         sources;	// {lfo, noise, vco}

	always_ff @(posedge clk) begin
		if (rst) begin
			prescale <= '0;
		end else begin
			prescale <= prescale + 1'b1;
		end
	end

	assign tick = (prescale == '0);

	snd_lfo snd_lfo_i (
		.clk       (clk),
		.rst       (rst),
		.tick      (tick),
		.lfo_freq  (lfo_freq),
		.lfo_shift (lfo_shift),
		.lfo_state (lfo_state),
		.vco_delta (vco_delta)
	);

	snd_vco snd_vco_i (
		.clk        (clk),
		.rst        (rst),
		.tick       (tick),
		.vco_freq   (vco_freq),
		.vco_select (vco_select),
		.vco_delta  (vco_delta),
		.vco_state  (vco_state)
	);

	snd_noise #(
		.TAPS(TAPS)
	) snd_noise_i (
		.clk          (clk),
		.rst          (rst),
		.tick         (tick),
		.noise_freq   (noise_freq),
		.noise_select (noise_select),
		.vco_delta    (vco_delta),
		.noise_state  (noise_state)
	);

	assign sources = {lfo_state, noise_state, vco_state};

	// A disabled source reads as one, so it never holds spkr low
	always_ff @(posedge clk) begin
		if (rst) begin
			spkr <= 1'b0;
		end else if (tick) begin
			spkr <= &(sources | ~mixer);
		end
	end

endmodule

`default_nettype wire

/* src/snd_noise.sv */
// Noise oscillator
// Reloading down-counter like the VCO; each reload steps the LFSR
// and toggles the output only when the LFSR low bit is one

`timescale 1ns/1ps
`default_nettype none

module snd_noise
	import snd_pkg::*;
#(
	parameter logic [LFSR_W-1:0] TAPS = LFSR_TAPS_DEFAULT
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  tick,
	input  logic [OSC_FREQ_W-1:0] noise_freq,
	input  logic                  noise_select,
	input  logic [OSC_FREQ_W-1:0] vco_delta,
	output logic                  noise_state
);

	logic [OSC_FREQ_W:0] noise_count;
	logic [OSC_FREQ_W:0] noise_load;
	logic [LFSR_W-1:0]   lfsr;
	logic                reload;	// Counter expired on this tick

	assign reload = tick && (noise_count == '0);

	// The LFSR advances on the same edge, so the toggle sees the old bit 0
	snd_lfsr #(
		.TAPS(TAPS)
	) snd_lfsr_i (
		.clk    (clk),
		.rst    (rst),
		.enable (reload),
		.lfsr   (lfsr)
	);

	always_comb begin
		if (noise_select) begin
			noise_load = {1'b0, noise_freq} + {1'b0, vco_delta};
		end else begin
			noise_load = {1'b0, noise_freq};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			noise_count <= '0;
			noise_state <= 1'b0;
		end else if (reload) begin
			if (lfsr[0]) begin
				noise_state <= ~noise_state;	// Random toggle
			end
			noise_count <= noise_load;
		end else if (tick) begin
			noise_count <= noise_count - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* src/snd_vco.sv */
// Square-wave VCO
// Reloading down-counter that toggles its output on every
// reload, with the LFO delta added to the load when selected

`timescale 1ns/1ps
`default_nettype none

module snd_vco
	import snd_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  tick,
	input  logic [OSC_FREQ_W-1:0] vco_freq,
	input  logic                  vco_select,
	input  logic [OSC_FREQ_W-1:0] vco_delta,
	output logic                  vco_state
);

	logic [OSC_FREQ_W:0] vco_count;	// One extra bit for the offset sum
	logic [OSC_FREQ_W:0] vco_load;

	// Sum can exceed the frequency field, hence the wider counter
	always_comb begin
		if (vco_select) begin
			vco_load = {1'b0, vco_freq} + {1'b0, vco_delta};
		end else begin
			vco_load = {1'b0, vco_freq};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			vco_count <= '0;	// Forces a reload on the first tick
			vco_state <= 1'b0;
		end else if (tick) begin
			if (vco_count == '0) begin
				vco_state <= ~vco_state;
				vco_count <= vco_load;
			end else begin
				vco_count <= vco_count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* src/snd_lfo.sv */
// Low-frequency oscillator
// Down-counter with square output, a triangle derived from
// the counter and the depth-shifted modulation delta

`timescale 1ns/1ps
`default_nettype none

module snd_lfo
	import snd_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  tick,
	input  logic [LFO_FREQ_W-1:0] lfo_freq,
	input  logic [SHIFT_W-1:0]    lfo_shift,
	output logic                  lfo_state,
	output logic [OSC_FREQ_W-1:0] vco_delta
);

	localparam int CNT_W = LFO_FREQ_W + 8;	// Frequency times 256

	logic [CNT_W-1:0]      lfo_count;
	logic [OSC_FREQ_W-1:0] lfo_triangle;
	logic [OSC_FREQ_W-1:0] count_top;	// Upper counter bits

	always_ff @(posedge clk) begin
		if (rst) begin
			lfo_count <= '0;	// Reloads on the first tick
			lfo_state <= 1'b0;
		end else if (tick) begin
			if (lfo_count == '0) begin
				lfo_state <= ~lfo_state;
				lfo_count <= {lfo_freq, 8'b0};
			end else begin
				lfo_count <= lfo_count - 1'b1;
			end
		end
	end

	// Folding the ramp at the MSB gives a triangle
	assign count_top    = lfo_count[CNT_W-1 -: OSC_FREQ_W];
	assign lfo_triangle = lfo_count[CNT_W-1] ? ~count_top : count_top;

	assign vco_delta = lfo_triangle >> lfo_shift;	// Modulation depth

endmodule

`default_nettype wire

/* src/snd_lfsr.sv */
// Galois LFSR noise source
// Shifts right on enable and folds in the tap mask
// whenever the outgoing bit is one

`timescale 1ns/1ps
`default_nettype none

module snd_lfsr
	import snd_pkg::*;
#(
	parameter logic [LFSR_W-1:0] TAPS = LFSR_TAPS_DEFAULT
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              enable,
	output logic [LFSR_W-1:0] lfsr
);

	logic [LFSR_W-1:0] feedback;	// Tap mask applied this step

	assign feedback = lfsr[0] ? TAPS : '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			lfsr <= LFSR_W'(1);	// Nonzero seed
		end else if (enable) begin
			lfsr <= (lfsr >> 1) ^ feedback;
		end
	end

endmodule

`default_nettype wire

/* src/snd_regs.sv */
// Wishbone classic slave register bank
// Holds the LFO, noise and VCO frequencies and the control word,
// generates a one-cycle ack and a zero-extended readback

`timescale 1ns/1ps
`default_nettype none

module snd_regs
	import snd_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,

	// Wishbone slave
	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  logic [WB_ADR_W-1:0]   wb_adr,
	input  logic [WB_DATA_W-1:0]  wb_dat_w,
	output logic [WB_DATA_W-1:0]  wb_dat_r,
	output logic                  wb_ack,

	// Configuration to the sound core
	output logic [LFO_FREQ_W-1:0] lfo_freq,
	output logic [OSC_FREQ_W-1:0] noise_freq,
	output logic [OSC_FREQ_W-1:0] vco_freq,
	output logic                  vco_select,
	output logic                  noise_select,
	output logic [SHIFT_W-1:0]    lfo_shift,
	output logic [MIX_W-1:0]      mixer
);

	logic                 access;	// Request sampled this edge
	logic [WB_DATA_W-1:0] rd_data;	// Readback mux output

	// A new request is taken only while ack is low, so each access is two cycles
	assign access = wb_cyc && wb_stb && !wb_ack;

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= access;	// High for exactly one cycle
		end
	end

	// Register writes, upper data bits ignored
	always_ff @(posedge clk) begin
		if (rst) begin
			lfo_freq     <= '0;
			noise_freq   <= '0;
			vco_freq     <= '0;
			vco_select   <= 1'b0;
			noise_select <= 1'b0;
			lfo_shift    <= '0;
			mixer        <= '0;
		end else if (access && wb_we) begin
			case (snd_reg_e'(wb_adr))
				REG_LFO_FREQ:   lfo_freq   <= wb_dat_w[LFO_FREQ_W-1:0];
				REG_NOISE_FREQ: noise_freq <= wb_dat_w[OSC_FREQ_W-1:0];
				REG_VCO_FREQ:   vco_freq   <= wb_dat_w[OSC_FREQ_W-1:0];
				REG_CTRL: begin
					vco_select   <= wb_dat_w[CTRL_VCO_SEL];
					noise_select <= wb_dat_w[CTRL_NOISE_SEL];
					lfo_shift    <= wb_dat_w[CTRL_SHIFT_LSB +: SHIFT_W];
					mixer        <= wb_dat_w[CTRL_MIX_LSB +: MIX_W];
				end
				default: ;
			endcase
		end
	end

	// Readback, zero-extended to the bus width
	always_comb begin
		rd_data = '0;
		case (snd_reg_e'(wb_adr))
			REG_LFO_FREQ:   rd_data[LFO_FREQ_W-1:0] = lfo_freq;
			REG_NOISE_FREQ: rd_data[OSC_FREQ_W-1:0] = noise_freq;
			REG_VCO_FREQ:   rd_data[OSC_FREQ_W-1:0] = vco_freq;
			REG_CTRL:       rd_data[CTRL_W-1:0] = {mixer, lfo_shift, noise_select, vco_select};
			default:        rd_data = '0;
		endcase
	end

	// Read data is captured with the request and presented alongside ack
	always_ff @(posedge clk) begin
		if (access && !wb_we) begin
			wb_dat_r <= rd_data;
		end
	end

endmodule

`default_nettype wire

/* src/snd_pkg.sv */
// Shared definitions for the sound chip
// Field widths, bus widths, register address enum,
// control word bit layout and the default LFSR tap mask

`default_nettype none

package snd_pkg;

	// Configuration field widths
	localparam int LFO_FREQ_W = 10;
	localparam int OSC_FREQ_W = 12;	// VCO and noise frequency
	localparam int SHIFT_W    = 3;	// Modulation depth
	localparam int MIX_W      = 3;	// Mixer enables {lfo, noise, vco}

	// Wishbone bus
	localparam int WB_DATA_W = 16;
	localparam int WB_ADR_W  = 2;	// Word address

	// Noise source
	localparam int LFSR_W = 16;
	localparam logic [LFSR_W-1:0] LFSR_TAPS_DEFAULT = 16'b0001000000001011;

	// Register map
	typedef enum logic [WB_ADR_W-1:0] {
		REG_LFO_FREQ   = 2'd0,
		REG_NOISE_FREQ = 2'd1,
		REG_VCO_FREQ   = 2'd2,
		REG_CTRL       = 2'd3
	} snd_reg_e;

	// Control word layout, LSB first
	localparam int CTRL_VCO_SEL   = 0;
	localparam int CTRL_NOISE_SEL = 1;
	localparam int CTRL_SHIFT_LSB = 2;	// Bits 4..2
	localparam int CTRL_MIX_LSB   = 5;	// Bits 7..5
	localparam int CTRL_W         = 8;

endpackage

`default_nettype wire
